/* hw/pim_dma_defines.svh */
`ifndef PIM_DMA_DEFINES_SVH
`define PIM_DMA_DEFINES_SVH

// pim register map
`define PIM_BASE_ADDR       32'h4000_0000   // array base
`define PIM_MODE_ADDR       32'h4100_0000   // mode register
`define PIM_ZP_ADDR         32'h4200_0000   // zero point register
`define PIM_STATUS_ADDR     32'h4300_0000   // bit 0 is ready

// burst lengths in words
`define PIM_BEATS_PARALLEL  16
`define PIM_BEATS_RBR       2

// beat index sits in pim address bits 19:16
`define PIM_BEAT_SHIFT      16

// sram pointer step per beat, full words only
`define SRAM_WORD_STRIDE    4

`endif

/* hw/pim_dma_pkg.sv */
`default_nettype none

package pim_dma_pkg;

    typedef logic [31:0] addr_t;    // bus address
    typedef logic [31:0] data_t;    // bus word
    typedef logic [4:0]  beat_t;    // beat count, must hold 16

    // funct3 encoding of the dma command
    // read and load are decoded only to be refused
    typedef enum logic [2:0] {
        OP_ERASE    = 3'd1,
        OP_PROGRAM  = 3'd2,
        OP_READ     = 3'd3,
        OP_ZP       = 3'd4,
        OP_PARALLEL = 3'd5,
        OP_RBR      = 3'd6,
        OP_LOAD     = 3'd7
    } pim_op_e;

endpackage

`default_nettype wire

/* hw/pim_cmd_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pim_dma_defines.svh"

module pim_cmd_regs (
    input  wire                         clk_i,
    input  wire                         rst_ni,
    input  wire                         dma_en_i,
    input  wire  [2:0]                  funct3_i,
    input  wire  pim_dma_pkg::addr_t    rs1_i,      // row/col offset
    input  wire  pim_dma_pkg::data_t    rs2_i,      // timing, zero point or buffer addr
    input  wire                         busy_i,
    input  wire  pim_dma_pkg::beat_t    beat_i,
    input  wire                         next_beat_i,
    output logic                        start_o,
    output pim_dma_pkg::pim_op_e        op_o,
    output pim_dma_pkg::data_t          operand_o,
    output pim_dma_pkg::beat_t          beats_o,
    output pim_dma_pkg::addr_t          sram_adr_o,
    output pim_dma_pkg::addr_t          pim_adr_o
);
    import pim_dma_pkg::*;

    logic  kept_op;
    logic  accept;
    addr_t offset_q;

    always_comb begin
        case (funct3_i)
            OP_ERASE, OP_PROGRAM, OP_ZP, OP_PARALLEL, OP_RBR: kept_op = 1'b1;
            OP_READ, OP_LOAD: kept_op = 1'b0;  // no pim-to-sram path
            default: kept_op = 1'b0;
        endcase
    end

    // start_o blocks the cycle before the sequencer raises busy
    assign accept = dma_en_i && !busy_i && !start_o && kept_op;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start_o <= 1'b0;
            op_o    <= OP_ERASE;
            beats_o <= '0;
        end else begin
            start_o <= accept;
            if (accept) begin
                op_o <= pim_op_e'(funct3_i);
                case (pim_op_e'(funct3_i))
                    OP_PARALLEL: beats_o <= beat_t'(`PIM_BEATS_PARALLEL);
                    OP_RBR:      beats_o <= beat_t'(`PIM_BEATS_RBR);
                    default:     beats_o <= beat_t'(1);     // single write
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            offset_q   <= rs1_i;
            operand_o  <= rs2_i;
            sram_adr_o <= rs2_i;
        end else if (next_beat_i) begin
            sram_adr_o <= sram_adr_o + addr_t'(`SRAM_WORD_STRIDE);
        end
    end

    // data write target per opcode
    always_comb begin
        case (op_o)
            OP_ZP:               pim_adr_o = addr_t'(`PIM_ZP_ADDR);
            OP_PARALLEL, OP_RBR: pim_adr_o = (addr_t'(`PIM_BASE_ADDR) + offset_q)
                                             | (addr_t'(beat_i) << `PIM_BEAT_SHIFT);
            default:             pim_adr_o = addr_t'(`PIM_BASE_ADDR) + offset_q;
        endcase
    end

    // no command reaches the sequencer while it is running
    assert property (@(posedge clk_i) disable iff (!rst_ni) start_o |-> !busy_i);
    // and it is taken up on the next edge
    assert property (@(posedge clk_i) disable iff (!rst_ni) start_o |=> busy_i);

endmodule

`default_nettype wire

/* hw/pim_wb_port.sv */
`timescale 1ns/1ps
`default_nettype none

module pim_wb_port (
    input  wire                         clk_i,
    input  wire                         rst_ni,
    input  wire                         start_i,
    input  wire                         we_i,
    input  wire  pim_dma_pkg::addr_t    adr_i,
    input  wire  pim_dma_pkg::data_t    dat_i,
    input  wire  pim_dma_pkg::data_t    pim_dat_i,
    input  wire                         pim_ack_i,
    output logic                        pim_cyc_o,
    output logic                        pim_stb_o,
    output logic                        pim_we_o,
    output pim_dma_pkg::addr_t          pim_adr_o,
    output pim_dma_pkg::data_t          pim_dat_o,
    output logic                        done_o,
    output logic                        ready_o
);

    logic cyc_q;

    assign pim_cyc_o = cyc_q;
    assign pim_stb_o = cyc_q;   // classic cycle, single transfer

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cyc_q    <= 1'b0;
            pim_we_o <= 1'b0;
            done_o   <= 1'b0;
            ready_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                cyc_q    <= 1'b1;
                pim_we_o <= we_i;
            end else if (cyc_q && pim_ack_i) begin
                cyc_q    <= 1'b0;
                pim_we_o <= 1'b0;
                done_o   <= 1'b1;
                if (!pim_we_o) begin
                    ready_o <= pim_dat_i[0];    // status ready bit
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            pim_adr_o <= adr_i;
            pim_dat_o <= dat_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pim_stb_o && !pim_ack_i |=> pim_stb_o && $stable(pim_adr_o) && $stable(pim_dat_o));
    // sequencer waits for done before the next request
    assert property (@(posedge clk_i) disable iff (!rst_ni) pim_cyc_o |-> !start_i);

endmodule

`default_nettype wire

/* hw/pim_dma_seq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pim_dma_defines.svh"

module pim_dma_seq (
    input  wire                         clk_i,
    input  wire                         rst_ni,
    input  wire                         start_i,
    input  wire  pim_dma_pkg::pim_op_e  op_i,
    input  wire  pim_dma_pkg::data_t    operand_i,
    input  wire  pim_dma_pkg::beat_t    beats_i,
    input  wire  pim_dma_pkg::addr_t    pim_adr_i,
    input  wire  pim_dma_pkg::addr_t    sram_adr_i,
    input  wire                         bus_gnt_i,
    input  wire  pim_dma_pkg::data_t    sram_dat_i,
    input  wire                         sram_ack_i,
    input  wire                         xfer_done_i,
    input  wire                         ready_i,
    output logic                        busy_o,
    output logic                        bus_req_o,
    output pim_dma_pkg::beat_t          beat_o,
    output logic                        next_beat_o,
    output logic                        sram_cyc_o,
    output logic                        sram_stb_o,
    output pim_dma_pkg::addr_t          sram_adr_o,
    output logic                        xfer_start_o,
    output logic                        xfer_we_o,
    output pim_dma_pkg::addr_t          xfer_adr_o,
    output pim_dma_pkg::data_t          xfer_dat_o
);
    import pim_dma_pkg::*;

    typedef enum logic [2:0] {IDLE, POLL, MODE, SRC_RD, DST_WR, DONE} state_e;

    state_e state_q;
    logic   issued_q;       // this state's bus cycle is out
    logic   burst;
    logic   last_beat;
    logic   sram_launch;
    data_t  rd_word_q;

    assign burst       = (op_i == OP_PARALLEL) || (op_i == OP_RBR);
    assign last_beat   = (beat_o + beat_t'(1)) == beats_i;
    assign busy_o      = (state_q != IDLE);
    assign bus_req_o   = busy_o;
    assign sram_stb_o  = sram_cyc_o;
    assign next_beat_o = (state_q == DST_WR) && xfer_done_i;
    assign sram_launch = (state_q == SRC_RD) && bus_gnt_i && !issued_q;

    // pim request, only launched on an edge with grant
    always_comb begin
        xfer_start_o = 1'b0;
        xfer_we_o    = 1'b0;
        xfer_adr_o   = addr_t'(`PIM_STATUS_ADDR);
        xfer_dat_o   = '0;
        case (state_q)
            POLL: xfer_start_o = bus_gnt_i && !issued_q;
            MODE: begin
                xfer_start_o = bus_gnt_i && !issued_q;
                xfer_we_o    = 1'b1;
                xfer_adr_o   = addr_t'(`PIM_MODE_ADDR);
                xfer_dat_o   = data_t'(op_i);  // opcode in low bits
            end
            DST_WR: begin
                xfer_start_o = bus_gnt_i && !issued_q;
                xfer_we_o    = 1'b1;
                xfer_adr_o   = pim_adr_i;
                xfer_dat_o   = burst ? rd_word_q : operand_i;
            end
            default: xfer_start_o = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            issued_q   <= 1'b0;
            beat_o     <= '0;
            sram_cyc_o <= 1'b0;
        end else begin
            if (xfer_start_o || sram_launch) begin
                issued_q <= 1'b1;
            end
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q  <= POLL;
                        issued_q <= 1'b0;
                        beat_o   <= '0;
                    end
                end
                POLL: begin
                    if (xfer_done_i) begin
                        issued_q <= 1'b0;
                        if (ready_i) begin
                            state_q <= MODE;
                        end                     // not ready, poll again
                    end
                end
                MODE: begin
                    if (xfer_done_i) begin
                        issued_q <= 1'b0;
                        state_q  <= burst ? SRC_RD : DST_WR;
                    end
                end
                SRC_RD: begin
                    if (sram_launch) begin
                        sram_cyc_o <= 1'b1;
                    end else if (sram_cyc_o && sram_ack_i) begin
                        sram_cyc_o <= 1'b0;
                        issued_q   <= 1'b0;
                        state_q    <= DST_WR;
                    end
                end
                DST_WR: begin
                    if (xfer_start_o && last_beat) begin
                        state_q <= DONE;        // last write in flight
                    end else if (xfer_done_i) begin
                        issued_q <= 1'b0;
                        beat_o   <= beat_o + beat_t'(1);
                        state_q  <= SRC_RD;
                    end
                end
                DONE: begin
                    if (xfer_done_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (sram_launch) begin
            sram_adr_o <= sram_adr_i;
        end
        if (sram_cyc_o && sram_ack_i) begin
            rd_word_q <= sram_dat_i;    // word for the next pim beat
        end
    end

    // an open sram read always completes inside the command
    assert property (@(posedge clk_i) disable iff (!rst_ni) sram_cyc_o |=> busy_o);

endmodule

`default_nettype wire

/* hw/pim_dma_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pim_dma_top (
    input  wire                         clk_i,
    input  wire                         rst_ni,
    // command
    input  wire                         dma_en_i,
    input  wire  [2:0]                  funct3_i,
    input  wire  pim_dma_pkg::addr_t    rs1_i,
    input  wire  pim_dma_pkg::data_t    rs2_i,
    output logic                        dma_busy_o,
    // arbitration
    output logic                        bus_req_o,
    input  wire                         bus_gnt_i,
    // sram, read only
    output logic                        sram_cyc_o,
    output logic                        sram_stb_o,
    output pim_dma_pkg::addr_t          sram_adr_o,
    input  wire  pim_dma_pkg::data_t    sram_dat_i,
    input  wire                         sram_ack_i,
    // pim
    output logic                        pim_cyc_o,
    output logic                        pim_stb_o,
    output logic                        pim_we_o,
    output pim_dma_pkg::addr_t          pim_adr_o,
    output pim_dma_pkg::data_t          pim_dat_o,
    input  wire  pim_dma_pkg::data_t    pim_dat_i,
    input  wire                         pim_ack_i
);
    import pim_dma_pkg::*;

    logic    start;
    pim_op_e op;
    data_t   operand;
    beat_t   beats;
    beat_t   beat;
    logic    next_beat;
    addr_t   sram_ptr;
    addr_t   pim_dst_adr;
    logic    xfer_start;
    logic    xfer_we;
    addr_t   xfer_adr;
    data_t   xfer_dat;
    logic    xfer_done;
    logic    pim_ready;

    pim_cmd_regs u_cmd (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .dma_en_i    (dma_en_i),
        .funct3_i    (funct3_i),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .busy_i      (dma_busy_o),
        .beat_i      (beat),
        .next_beat_i (next_beat),
        .start_o     (start),
        .op_o        (op),
        .operand_o   (operand),
        .beats_o     (beats),
        .sram_adr_o  (sram_ptr),
        .pim_adr_o   (pim_dst_adr)
    );

    pim_dma_seq u_seq (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (start),
        .op_i         (op),
        .operand_i    (operand),
        .beats_i      (beats),
        .pim_adr_i    (pim_dst_adr),
        .sram_adr_i   (sram_ptr),
        .bus_gnt_i    (bus_gnt_i),
        .sram_dat_i   (sram_dat_i),
        .sram_ack_i   (sram_ack_i),
        .xfer_done_i  (xfer_done),
        .ready_i      (pim_ready),
        .busy_o       (dma_busy_o),
        .bus_req_o    (bus_req_o),
        .beat_o       (beat),
        .next_beat_o  (next_beat),
        .sram_cyc_o   (sram_cyc_o),
        .sram_stb_o   (sram_stb_o),
        .sram_adr_o   (sram_adr_o),
        .xfer_start_o (xfer_start),
        .xfer_we_o    (xfer_we),
        .xfer_adr_o   (xfer_adr),
        .xfer_dat_o   (xfer_dat)
    );

    pim_wb_port u_pim (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .start_i   (xfer_start),
        .we_i      (xfer_we),
        .adr_i     (xfer_adr),
        .dat_i     (xfer_dat),
        .pim_dat_i (pim_dat_i),
        .pim_ack_i (pim_ack_i),
        .pim_cyc_o (pim_cyc_o),
        .pim_stb_o (pim_stb_o),
        .pim_we_o  (pim_we_o),
        .pim_adr_o (pim_adr_o),
        .pim_dat_o (pim_dat_o),
        .done_o    (xfer_done),
        .ready_o   (pim_ready)
    );

endmodule

`default_nettype wire

/* dv/pim_dma_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pim_dma_defines.svh"

module pim_dma_checker (
    input  wire                         clk_i,
    input  wire                         rst_ni,
    // table row as seen in its apply cycle
    input  wire                         row_valid_i,
    input  wire                         row_runs_i,
    input  wire  [2:0]                  row_op_i,
    input  wire  pim_dma_pkg::addr_t    row_rs1_i,
    input  wire  pim_dma_pkg::data_t    row_rs2_i,
    // dut ports
    input  wire                         busy_i,
    input  wire                         req_i,
    input  wire                         gnt_i,
    input  wire                         sram_cyc_i,
    input  wire                         sram_stb_i,
    input  wire  pim_dma_pkg::addr_t    sram_adr_i,
    input  wire                         sram_ack_i,
    input  wire                         pim_cyc_i,
    input  wire                         pim_stb_i,
    input  wire                         pim_we_i,
    input  wire  pim_dma_pkg::addr_t    pim_adr_i,
    input  wire  pim_dma_pkg::data_t    pim_wdat_i,
    input  wire  pim_dma_pkg::data_t    pim_rdat_i,
    input  wire                         pim_ack_i,
    output int                          err_count_o
);
    import pim_dma_pkg::*;

    addr_t exp_adr_q[$];    // pim writes still to come
    data_t exp_dat_q[$];
    addr_t exp_src_q[$];    // sram reads still to come
    int    errors = 0;
    logic  pending;         // a command is running
    logic  ready_seen;
    logic  [1:0] start_due; // accepted command, busy due two edges later
    logic  prev_busy;
    logic  prev_gnt;
    logic  prev_sram_cyc;
    logic  prev_pim_cyc;
    addr_t exp_adr;
    data_t exp_dat;

    assign err_count_o = errors;

    task automatic value_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
        $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
        errors++;
    endtask

    task automatic protocol_error(input string msg);
        $display("error at t=%0t: %s", $time, msg);
        errors++;
    endtask

    // mode write first, then the data writes in order
    task automatic load_expected(input logic [2:0] op, input addr_t rs1, input data_t rs2);
        int    beats;
        int    b;
        addr_t src;
        beats = (op == OP_PARALLEL) ? `PIM_BEATS_PARALLEL : `PIM_BEATS_RBR;
        exp_adr_q.push_back(`PIM_MODE_ADDR);
        exp_dat_q.push_back(data_t'(op));
        if (op == OP_ZP) begin
            exp_adr_q.push_back(`PIM_ZP_ADDR);
            exp_dat_q.push_back(rs2);
        end else if (op == OP_ERASE || op == OP_PROGRAM) begin
            exp_adr_q.push_back(`PIM_BASE_ADDR + rs1);
            exp_dat_q.push_back(rs2);
        end else begin
            for (b = 0; b < beats; b++) begin
                src = rs2 + addr_t'(`SRAM_WORD_STRIDE * b);
                exp_src_q.push_back(src);
                exp_adr_q.push_back((`PIM_BASE_ADDR + rs1) | (addr_t'(b) << `PIM_BEAT_SHIFT));
                exp_dat_q.push_back(~src);  // sram model answers with inverted address
            end
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            if ((busy_i | req_i | sram_cyc_i | sram_stb_i | pim_cyc_i | pim_stb_i | pim_we_i)
                === 1'b1) begin
                protocol_error("control output high during reset");
            end
            pending       <= 1'b0;
            ready_seen    <= 1'b0;
            start_due     <= '0;
            prev_busy     <= 1'b0;
            prev_gnt      <= 1'b0;
            prev_sram_cyc <= 1'b0;
            prev_pim_cyc  <= 1'b0;
        end else begin
            if (row_valid_i) begin
                if (exp_adr_q.size() != 0 || exp_src_q.size() != 0) begin
                    protocol_error("transfers of the previous command never appeared");
                end
                exp_adr_q.delete();
                exp_dat_q.delete();
                exp_src_q.delete();
                if (row_runs_i) begin
                    load_expected(row_op_i, row_rs1_i, row_rs2_i);
                    pending <= 1'b1;
                end
            end
            if (start_due[1] && busy_i !== 1'b1) begin
                protocol_error("busy not raised in the cycle after the command was taken");
            end
            start_due <= {start_due[0], row_valid_i && row_runs_i};
            if (req_i !== busy_i) begin
                value_mismatch("bus_req_o", 32'(busy_i), 32'(req_i));
            end
            if (busy_i && !pending) begin
                protocol_error("busy high with no command accepted");
            end
            // classic single transfers, stb follows cyc
            if (sram_stb_i !== sram_cyc_i) begin
                value_mismatch("sram_stb_o", 32'(sram_cyc_i), 32'(sram_stb_i));
            end
            if (pim_stb_i !== pim_cyc_i) begin
                value_mismatch("pim_stb_o", 32'(pim_cyc_i), 32'(pim_stb_i));
            end
            // launch decisions were made on the previous edge
            if (sram_cyc_i && !prev_sram_cyc && !prev_gnt) begin
                protocol_error("sram cycle started without grant");
            end
            if (pim_cyc_i && !prev_pim_cyc && !prev_gnt) begin
                protocol_error("pim cycle started without grant");
            end
            if (sram_cyc_i && pim_cyc_i) begin
                protocol_error("sram and pim cycles open at once");
            end
            if (sram_cyc_i && sram_ack_i) begin
                if (exp_src_q.size() == 0) begin
                    protocol_error("unexpected sram read");
                end else begin
                    exp_adr = exp_src_q.pop_front();
                    if (sram_adr_i !== exp_adr) value_mismatch("sram_adr_o", exp_adr, sram_adr_i);
                end
            end
            if (pim_cyc_i && pim_ack_i && !pim_we_i) begin     // status poll
                if (pim_adr_i !== `PIM_STATUS_ADDR) begin
                    value_mismatch("pim_adr_o", `PIM_STATUS_ADDR, pim_adr_i);
                end
                if (pim_rdat_i[0]) ready_seen <= 1'b1;
            end
            if (pim_cyc_i && pim_ack_i && pim_we_i) begin
                if (exp_adr_q.size() == 0) begin
                    protocol_error("unexpected pim write");
                end else begin
                    exp_adr = exp_adr_q.pop_front();
                    exp_dat = exp_dat_q.pop_front();
                    if (exp_adr == `PIM_MODE_ADDR) begin
                        if (!ready_seen) protocol_error("mode write before status reported ready");
                        ready_seen <= 1'b0;
                    end
                    if (pim_adr_i !== exp_adr) value_mismatch("pim_adr_o", exp_adr, pim_adr_i);
                    if (pim_wdat_i !== exp_dat) value_mismatch("pim_dat_o", exp_dat, pim_wdat_i);
                end
            end
            if (prev_busy && !busy_i) begin
                if (exp_adr_q.size() != 0 || exp_src_q.size() != 0) begin
                    protocol_error($sformatf("busy fell with %0d pim writes still missing",
                                             exp_adr_q.size()));
                end
                pending <= 1'b0;
            end
            prev_busy     <= busy_i;
            prev_gnt      <= gnt_i;
            prev_sram_cyc <= sram_cyc_i;
            prev_pim_cyc  <= pim_cyc_i;
        end
    end

endmodule

`default_nettype wire

/* dv/pim_dma_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pim_dma_defines.svh"

module pim_dma_tb;
    import pim_dma_pkg::*;

    localparam int NUM_ROWS    = 10;
    localparam int CYCLE_LIMIT = NUM_ROWS * 200;

    // runs, poke while busy, funct3, rs1 offset, rs2 operand
    localparam logic [68:0] CMD_TABLE [0:NUM_ROWS-1] = '{
        {1'b1, 1'b0, 3'd1, 32'h0000_0120, 32'h0000_0064},   // erase
        {1'b1, 1'b1, 3'd2, 32'h0000_0044, 32'h0000_01f4},   // program
        {1'b1, 1'b0, 3'd4, 32'h0000_0000, 32'h0000_0080},   // zero point
        {1'b1, 1'b0, 3'd5, 32'h0000_0200, 32'h0000_1000},   // parallel
        {1'b0, 1'b0, 3'd3, 32'h0000_0010, 32'h0000_0020},   // read, refused
        {1'b1, 1'b1, 3'd6, 32'h0000_0300, 32'h0000_2040},   // rbr
        {1'b0, 1'b0, 3'd7, 32'h0000_0010, 32'h0000_0020},   // load, refused
        {1'b1, 1'b0, 3'd5, 32'h0000_0008, 32'h0000_3ffc},
        {1'b1, 1'b0, 3'd1, 32'h0000_0fff, 32'hdead_0001},
        {1'b0, 1'b0, 3'd0, 32'h0000_0004, 32'h0000_0008}    // opcode 0 closes the table
    };

    logic   clk       = 1'b0;
    logic   rst_n     = 1'b0;
    logic   dma_en    = 1'b0;
    logic   [2:0] funct3 = 3'd0;
    addr_t  rs1       = '0;
    data_t  rs2       = '0;
    logic   row_valid = 1'b0;
    logic   row_runs  = 1'b0;
    logic   bus_gnt   = 1'b0;
    data_t  sram_dat  = '0;
    logic   sram_ack  = 1'b0;
    data_t  pim_dat   = '0;
    logic   pim_ack   = 1'b0;
    logic   dma_busy;
    logic   bus_req;
    logic   sram_cyc;
    logic   sram_stb;
    addr_t  sram_adr;
    logic   pim_cyc;
    logic   pim_stb;
    logic   pim_we;
    addr_t  pim_adr;
    data_t  pim_wdat;
    int     err_count;
    integer seed      = 32'h0cfa_b2c2;
    int     cycles    = 0;
    int     sram_wait = 0;
    int     pim_wait  = 0;
    int     not_ready = 2;     // status polls left before ready

    pim_dma_top uut (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .dma_en_i   (dma_en),
        .funct3_i   (funct3),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .dma_busy_o (dma_busy),
        .bus_req_o  (bus_req),
        .bus_gnt_i  (bus_gnt),
        .sram_cyc_o (sram_cyc),
        .sram_stb_o (sram_stb),
        .sram_adr_o (sram_adr),
        .sram_dat_i (sram_dat),
        .sram_ack_i (sram_ack),
        .pim_cyc_o  (pim_cyc),
        .pim_stb_o  (pim_stb),
        .pim_we_o   (pim_we),
        .pim_adr_o  (pim_adr),
        .pim_dat_o  (pim_wdat),
        .pim_dat_i  (pim_dat),
        .pim_ack_i  (pim_ack)
    );

    pim_dma_checker chk (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .row_valid_i (row_valid),
        .row_runs_i  (row_runs),
        .row_op_i    (funct3),
        .row_rs1_i   (rs1),
        .row_rs2_i   (rs2),
        .busy_i      (dma_busy),
        .req_i       (bus_req),
        .gnt_i       (bus_gnt),
        .sram_cyc_i  (sram_cyc),
        .sram_stb_i  (sram_stb),
        .sram_adr_i  (sram_adr),
        .sram_ack_i  (sram_ack),
        .pim_cyc_i   (pim_cyc),
        .pim_stb_i   (pim_stb),
        .pim_we_i    (pim_we),
        .pim_adr_i   (pim_adr),
        .pim_wdat_i  (pim_wdat),
        .pim_rdat_i  (pim_dat),
        .pim_ack_i   (pim_ack),
        .err_count_o (err_count)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic int rand_below(input int span);
        return int'($unsigned($random(seed)) % span);
    endfunction

    // grant and both slave models draw from one random sequence
    always @(posedge clk) begin
        if (!rst_n) begin
            bus_gnt  <= 1'b0;
            sram_ack <= 1'b0;
            pim_ack  <= 1'b0;
        end else begin
            bus_gnt <= (rand_below(4) != 0);    // low about one edge in four
            if (sram_ack) begin
                sram_ack <= 1'b0;
            end else if (sram_cyc && sram_stb) begin
                if (sram_wait == 0) begin
                    sram_ack  <= 1'b1;
                    sram_dat  <= ~sram_adr;
                    sram_wait <= rand_below(3);
                end else begin
                    sram_wait <= sram_wait - 1;
                end
            end
            if (pim_ack) begin
                pim_ack <= 1'b0;
            end else if (pim_cyc && pim_stb) begin
                if (pim_wait == 0) begin
                    pim_ack  <= 1'b1;
                    pim_wait <= rand_below(3);
                    if (!pim_we) begin
                        pim_dat <= (not_ready == 0) ? 32'd1 : 32'd0;
                        if (not_ready != 0) not_ready <= not_ready - 1;
                    end else if (pim_adr == `PIM_MODE_ADDR) begin
                        not_ready <= rand_below(4);     // polls for the next command
                    end
                end else begin
                    pim_wait <= pim_wait - 1;
                end
            end
        end
    end

    task automatic end_run(input bit timed_out);
        $display("run finished: %0d check errors, %0d timeouts", err_count, timed_out);
        if (err_count == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: no end of run within %0d cycles", CYCLE_LIMIT);
            end_run(1'b1);
        end
    end

    task automatic apply_row(input logic [68:0] row);
        @(posedge clk);
        dma_en    <= 1'b1;
        funct3    <= row[66:64];
        rs1       <= row[63:32];
        rs2       <= row[31:0];
        row_valid <= 1'b1;
        row_runs  <= row[68];
        @(posedge clk);
        dma_en    <= 1'b0;
        row_valid <= 1'b0;
        if (row[68]) begin
            while (dma_busy !== 1'b1) begin
                @(posedge clk);
            end
            if (row[67]) begin
                dma_en <= 1'b1;     // second command while busy
                funct3 <= 3'd2;
                rs1    <= 32'h0000_0777;
                rs2    <= 32'h5555_aaaa;
                @(posedge clk);
                dma_en <= 1'b0;
            end
            while (dma_busy !== 1'b0) begin
                @(posedge clk);
            end
        end else begin
            repeat (8) @(posedge clk);  // room for a wrong start to show
        end
    endtask

    initial begin
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(CMD_TABLE[i]);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        end_run(1'b0);
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hw
hw/pim_dma_pkg.sv
hw/pim_cmd_regs.sv
hw/pim_wb_port.sv
hw/pim_dma_seq.sv
hw/pim_dma_top.sv
dv/pim_dma_checker.sv
dv/pim_dma_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= pim_dma_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
